/* Bender.yml */
package:
  name: rvc_decode

sources:
  - files:
      - hw/rvcDecPkg.sv
      - hw/rvcOpTable.sv
      - hw/rvcOperandSel.sv
      - hw/rvcPrivGate.sv
      - hw/rvcDecodeStage.sv
  - target: simulation
    files:
      - sim/rvcDecodeTb.sv

/* hw/rvcDecPkg.sv */
`default_nettype none

package rvcDecPkg;

	// register ids, special bank is 7'b100_xxxx
	typedef logic [6:0] gprIdT;

	localparam gprIdT GR_DLR = 7'h40; // field 0 lands here
	localparam gprIdT GR_GBR = 7'h41;
	localparam gprIdT GR_PC  = 7'h42;
	localparam gprIdT GR_ZZR = 7'h4C;
	localparam gprIdT GR_IMM = 7'h4D; // operand comes from imm
	localparam gprIdT GR_SP  = 7'h4F; // field 15 lands here

	// operand forms
	typedef logic [4:0] fmidT;

	localparam fmidT FMID_INV      = 5'd0;
	localparam fmidT FMID_Z        = 5'd1;
	localparam fmidT FMID_REGREG   = 5'd2;
	localparam fmidT FMID_IMM8     = 5'd3;
	localparam fmidT FMID_IMM8REG  = 5'd4;
	localparam fmidT FMID_IMM4ZREG = 5'd5;
	localparam fmidT FMID_LDREGREG = 5'd6;
	localparam fmidT FMID_PCDISP8  = 5'd7;
	localparam fmidT FMID_IMM12Z   = 5'd8;

	// form sub-types
	typedef logic [3:0] ityT;

	localparam ityT ITY_SB = 4'd0;
	localparam ityT ITY_SW = 4'd1;
	localparam ityT ITY_SL = 4'd2;
	localparam ityT ITY_SQ = 4'd3;
	localparam ityT ITY_UB = 4'd4; // Rm -> Cn
	localparam ityT ITY_UW = 4'd5; // Cm -> Rn
	localparam ityT ITY_NB = 4'd8;
	localparam ityT ITY_NW = 4'd9;

	// operations
	typedef logic [5:0] nmidT;

	localparam nmidT UCMD_INVOP = 6'd0;
	localparam nmidT UCMD_NOP   = 6'd1;
	localparam nmidT UCMD_MOV   = 6'd2;
	localparam nmidT UCMD_ADD   = 6'd3;
	localparam nmidT UCMD_SUB   = 6'd4;
	localparam nmidT UCMD_AND   = 6'd5;
	localparam nmidT UCMD_LDI   = 6'd6;
	localparam nmidT UCMD_SHL   = 6'd7;
	localparam nmidT UCMD_LOAD  = 6'd8;
	localparam nmidT UCMD_BRA   = 6'd9;

	localparam logic [2:0] CC_AL = 3'b000; // condition "always"
	localparam logic [2:0] UC_SC = 3'b000; // single-cycle class

	typedef enum logic [1:0] {
		PRIV_NONE    = 2'd0,
		PRIV_CRREAD  = 2'd1,
		PRIV_CRWRITE = 2'd2
	} privClassT;

	// user mode reject masks, indexed by control register number
	localparam logic [15:0] CR_READ_REJECT  = 16'hFF38;
	localparam logic [15:0] CR_WRITE_REJECT = 16'hFFBC;

	typedef struct packed {
		nmidT       nmid;
		fmidT       fmid;
		ityT        ity;
		logic [2:0] bty;   // access size for loads
		logic [5:0] ixCmd;
		privClassT  privClass;
	} opClassT;

	typedef struct packed {
		gprIdT       regN;
		gprIdT       regM;
		gprIdT       regO;
		logic [32:0] imm;
		logic [8:0]  uCmd;
		logic [8:0]  uIxt;
		privClassT   privClass;
	} decOpT;

	localparam decOpT OP_INVALID = '{
		regN:      GR_ZZR,
		regM:      GR_ZZR,
		regO:      GR_ZZR,
		imm:       33'd0,
		uCmd:      {CC_AL, UCMD_INVOP},
		uIxt:      {UC_SC, UCMD_INVOP},
		privClass: PRIV_NONE
	};

endpackage

`default_nettype wire

/* hw/rvcDecodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module rvcDecodeStage (
	input  wire logic              clock,
	input  wire logic              rstN,
	input  wire logic [15:0]       istrWord,
	input  wire logic              istrValid,
	input  wire logic [2:0]        srMod,
	output logic                   opValid,
	output rvcDecPkg::decOpT       op
);

	import rvcDecPkg::*;

	opClassT opClass; // table -> selector
	decOpT   rawOp;   // selector -> gate

	rvcOpTable rvcOpTable_inst (
		.istrWord (istrWord),
		.opClass  (opClass)
	);

	rvcOperandSel rvcOperandSel_inst (
		.istrWord (istrWord),
		.opClass  (opClass),
		.rawOp    (rawOp)
	);

	// only clocked stage
	rvcPrivGate rvcPrivGate_inst (
		.clock     (clock),
		.rstN      (rstN),
		.srMod     (srMod),
		.istrValid (istrValid),
		.rawOp     (rawOp),
		.opValid   (opValid),
		.op        (op)
	);

endmodule

`default_nettype wire

/* hw/rvcOpTable.sv */
`timescale 1ns/1ps
`default_nettype none

module rvcOpTable (
	input  wire logic [15:0]       istrWord,
	output rvcDecPkg::opClassT     opClass
);

	import rvcDecPkg::*;

	opClassT cls;
	logic [3:0] majorOp;
	logic [3:0] subOp;

	assign majorOp = istrWord[15:12];
	assign subOp   = istrWord[11:8];

	always_comb begin
		cls           = '0;
		cls.nmid      = UCMD_INVOP;
		cls.fmid      = FMID_INV;
		cls.ity       = ITY_SB;
		cls.privClass = PRIV_NONE;

		casez (majorOp)
			4'b0000: begin // two-register ops
				cls.fmid = FMID_REGREG;
				case (subOp)
					4'h0: begin
						cls.ity  = ITY_SB;
						cls.nmid = UCMD_MOV;
					end
					4'h1: begin
						cls.ity  = ITY_NB;
						cls.nmid = UCMD_ADD;
					end
					4'h2: begin
						cls.ity  = ITY_NW;
						cls.nmid = UCMD_SUB;
					end
					4'h3: begin
						cls.ity  = ITY_NB;
						cls.nmid = UCMD_AND;
					end
					4'h4: begin // Rm -> Cn
						cls.ity       = ITY_UB;
						cls.nmid      = UCMD_MOV;
						cls.privClass = PRIV_CRWRITE;
					end
					4'h5: begin // Cm -> Rn
						cls.ity       = ITY_UW;
						cls.nmid      = UCMD_MOV;
						cls.privClass = PRIV_CRREAD;
					end
					default: cls.fmid = FMID_INV; // reserved sub-opcode
				endcase
			end
			4'b0001: begin
				cls.fmid = FMID_IMM8;
				cls.nmid = UCMD_LDI;
			end
			4'b0010: begin
				cls.fmid = FMID_IMM8REG;
				cls.nmid = UCMD_ADD;
			end
			4'b0011: begin
				cls.fmid = FMID_IMM4ZREG;
				cls.ity  = ITY_SB;
				cls.nmid = UCMD_SHL;
			end
			4'b0100: begin
				cls.fmid = FMID_LDREGREG;
				cls.nmid = UCMD_LOAD;
				cls.bty  = subOp[2:0]; // size from sub-opcode
			end
			4'b0101: begin
				cls.fmid = FMID_PCDISP8;
				cls.nmid = UCMD_BRA;
			end
			4'b0110: begin
				cls.fmid = FMID_IMM12Z;
				cls.nmid = UCMD_LDI;
			end
			4'b0111: begin
				cls.fmid = FMID_Z;
				cls.nmid = UCMD_NOP;
			end
			4'b1???: ; // upper half unassigned
			default: ;
		endcase

		cls.ixCmd = cls.nmid;
	end

	assign opClass = cls;

endmodule

`default_nettype wire

/* hw/rvcOperandSel.sv */
`timescale 1ns/1ps
`default_nettype none

module rvcOperandSel (
	input  wire logic [15:0]       istrWord,
	input  wire rvcDecPkg::opClassT opClass,
	output rvcDecPkg::decOpT       rawOp
);

	import rvcDecPkg::*;

	decOpT op;

	logic spcO;
	logic spcN;
	logic spcM;

	gprIdT dflO;
	gprIdT dflN;
	gprIdT dflM;
	gprIdT crN;
	gprIdT crM;

	logic [32:0] imm8s;
	logic [32:0] imm4z;
	logic [32:0] imm12z;

	// fields 0 and 15 go to the special bank
	assign spcO = (istrWord[11:8] == 4'h0) || (istrWord[11:8] == 4'hF);
	assign spcN = (istrWord[7:4] == 4'h0) || (istrWord[7:4] == 4'hF);
	assign spcM = (istrWord[3:0] == 4'h0) || (istrWord[3:0] == 4'hF);

	assign dflO = {spcO, 2'b00, istrWord[11:8]};
	assign dflN = {spcN, 2'b00, istrWord[7:4]};
	assign dflM = {spcM, 2'b00, istrWord[3:0]};

	assign crN = {3'b110, istrWord[7:4]}; // control regs
	assign crM = {3'b110, istrWord[3:0]};

	assign imm8s  = {{25{istrWord[7]}}, istrWord[7:0]};
	assign imm4z  = {29'd0, istrWord[3:0]};
	assign imm12z = {21'd0, istrWord[11:0]};

	always_comb begin
		op           = OP_INVALID;
		op.uCmd      = {CC_AL, opClass.nmid};
		op.uIxt      = {UC_SC, opClass.ixCmd};
		op.privClass = opClass.privClass;

		case (opClass.fmid)
			FMID_REGREG: begin
				op.regN = dflN;
				op.regM = dflM;
				op.regO = GR_DLR;
				case (opClass.ity)
					ITY_NB: begin // Rn op Rm -> Rn
						op.regM = dflN;
						op.regO = dflM;
					end
					ITY_NW: begin
						op.regO = dflN;
					end
					ITY_UB: op.regN = crN;
					ITY_UW: op.regM = crM;
					default: ; // SB keeps the defaults
				endcase
			end

			FMID_IMM8: begin
				op.regN = GR_DLR;
				op.imm  = imm8s;
			end

			FMID_IMM8REG: begin
				op.regN = dflO;
				op.regM = dflO;
				op.regO = GR_IMM;
				op.imm  = imm8s;
			end

			FMID_IMM4ZREG: begin
				op.regN = dflN;
				op.regM = GR_IMM;
				op.regO = dflN;
				op.imm  = imm4z;
			end

			FMID_LDREGREG: begin
				op.regN = dflN;
				op.regM = dflM;
				op.uIxt = {UC_SC, opClass.bty[1:0], 1'b1, opClass.bty};
			end

			FMID_PCDISP8: begin
				op.regN = GR_DLR;
				op.regM = GR_PC;
				op.regO = GR_IMM;
				op.imm  = imm8s;
				op.uIxt = {UC_SC, opClass.bty[1:0], 1'b0, opClass.bty};
			end

			FMID_IMM12Z: begin
				op.regN = GR_DLR;
				op.regM = GR_DLR; // DLR += imm
				op.regO = GR_IMM;
				op.imm  = imm12z;
			end

			default: ; // Z and INV use no operands
		endcase
	end

	assign rawOp = op;

endmodule

`default_nettype wire

/* hw/rvcPrivGate.sv */
`timescale 1ns/1ps
`default_nettype none

module rvcPrivGate (
	input  wire logic              clock,
	input  wire logic              rstN,
	input  wire logic [2:0]        srMod,
	input  wire logic              istrValid,
	input  wire rvcDecPkg::decOpT  rawOp,
	output logic                   opValid,
	output rvcDecPkg::decOpT       op
);

	import rvcDecPkg::*;

	logic  userMode;
	logic  rejWrite;
	logic  rejRead;
	decOpT gatedOp;

	assign userMode = srMod[0];

	// write index is the destination, read index the source
	assign rejWrite = (rawOp.privClass == PRIV_CRWRITE) && CR_WRITE_REJECT[rawOp.regN[3:0]];
	assign rejRead  = (rawOp.privClass == PRIV_CRREAD) && CR_READ_REJECT[rawOp.regM[3:0]];

	always_comb begin
		gatedOp = rawOp;
		if (userMode && (rejWrite || rejRead)) begin
			gatedOp.uCmd = {rawOp.uCmd[8:6], UCMD_INVOP}; // registers stay as decoded
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			opValid <= 1'b0;
			op      <= OP_INVALID;
		end else begin
			opValid <= istrValid;
			if (istrValid) begin
				op <= gatedOp; // hold last op between strobes
			end
		end
	end

endmodule

`default_nettype wire

/* sim/rvcDecodeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvcDecodeTb;

	import rvcDecPkg::*;

	localparam int CLOCK_NS     = 100;
	localparam int RESET_CYCLES = 10;
	localparam int WORDS_TESTED = 201; // sum of the words driven by all tests
	localparam int WATCHDOG_NS  = 2 * WORDS_TESTED * CLOCK_NS + RESET_CYCLES * CLOCK_NS;

	// user mode reject masks, bit n for control register n
	localparam logic [15:0] WRITE_MASK = 16'hFFBC;
	localparam logic [15:0] READ_MASK  = 16'hFF38;

	logic        clock;
	logic        rstN;
	logic [15:0] istrWord;
	logic        istrValid;
	logic [2:0]  srMod;
	logic        opValid;
	decOpT       op;

	int          errCount;
	int          checkCount;
	integer      seed;
	logic [15:0] curWord; // last word driven, shown in error lines

	rvcDecodeStage rvcDecodeStage_inst (
		.clock     (clock),
		.rstN      (rstN),
		.istrWord  (istrWord),
		.istrValid (istrValid),
		.srMod     (srMod),
		.opValid   (opValid),
		.op        (op)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_NS / 2) clock = ~clock;
	end

	task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("FAIL %s got 0x%0h expected 0x%0h (word 0x%04h)", name, got, exp, curWord);
		end
	endtask

	function automatic gprIdT fieldId(input logic [3:0] f);
		gprIdT id;
		id = {3'b000, f};
		if (f == 4'h0 || f == 4'hF)
			id[6] = 1'b1; // special bank
		return id;
	endfunction

	function automatic decOpT invalidOp();
		decOpT e;
		e.regN      = GR_ZZR;
		e.regM      = GR_ZZR;
		e.regO      = GR_ZZR;
		e.imm       = '0;
		e.uCmd      = {CC_AL, UCMD_INVOP};
		e.uIxt      = {UC_SC, UCMD_INVOP};
		e.privClass = PRIV_NONE;
		return e;
	endfunction

	// reference model of the decode rules
	function automatic decOpT expectOp(input logic [15:0] w, input logic [2:0] mode);
		decOpT e;
		nmidT  decoded; // operation before the privilege gate
		logic  reject;
		logic  btyForm;
		e       = invalidOp();
		decoded = UCMD_INVOP;
		reject  = 1'b0;
		btyForm = 1'b0;
		case (w[15:12])
			4'h0: begin
				e.regN = fieldId(w[7:4]);
				e.regM = fieldId(w[3:0]);
				e.regO = GR_DLR;
				case (w[11:8])
					4'h0: decoded = UCMD_MOV;
					4'h1, 4'h3: begin
						decoded = (w[11:8] == 4'h1) ? UCMD_ADD : UCMD_AND;
						e.regM  = fieldId(w[7:4]);
						e.regO  = fieldId(w[3:0]);
					end
					4'h2: begin
						decoded = UCMD_SUB;
						e.regO  = fieldId(w[7:4]);
					end
					4'h4: begin
						decoded = UCMD_MOV;
						e.regN  = {3'b110, w[7:4]};
						reject  = mode[0] && WRITE_MASK[w[7:4]];
					end
					4'h5: begin
						decoded = UCMD_MOV;
						e.regM  = {3'b110, w[3:0]};
						reject  = mode[0] && READ_MASK[w[3:0]];
					end
					default: e = invalidOp();
				endcase
			end
			4'h1: begin
				decoded = UCMD_LDI;
				e.regN  = GR_DLR;
				e.imm   = 33'($signed(w[7:0]));
			end
			4'h2: begin
				decoded = UCMD_ADD;
				e.regN  = fieldId(w[11:8]);
				e.regM  = fieldId(w[11:8]);
				e.regO  = GR_IMM;
				e.imm   = 33'($signed(w[7:0]));
			end
			4'h3: begin
				decoded = UCMD_SHL;
				e.regN  = fieldId(w[7:4]);
				e.regM  = GR_IMM;
				e.regO  = fieldId(w[7:4]);
				e.imm   = 33'(w[3:0]);
			end
			4'h4: begin
				decoded = UCMD_LOAD;
				e.regN  = fieldId(w[7:4]);
				e.regM  = fieldId(w[3:0]);
				btyForm = 1'b1;
				e.uIxt  = {UC_SC, w[9:8], 1'b1, w[10:8]};
			end
			4'h5: begin
				decoded = UCMD_BRA;
				e.regN  = GR_DLR;
				e.regM  = GR_PC;
				e.regO  = GR_IMM;
				e.imm   = 33'($signed(w[7:0]));
				btyForm = 1'b1;
				e.uIxt  = {UC_SC, 2'b00, 1'b0, 3'b000}; // no size for branches
			end
			4'h6: begin
				decoded = UCMD_LDI;
				e.regN  = GR_DLR;
				e.regM  = GR_DLR;
				e.regO  = GR_IMM;
				e.imm   = 33'(w[11:0]);
			end
			4'h7: decoded = UCMD_NOP;
			default: decoded = UCMD_INVOP;
		endcase
		e.uCmd = {CC_AL, (reject ? UCMD_INVOP : decoded)};
		if (!btyForm)
			e.uIxt = {UC_SC, decoded};
		return e;
	endfunction

	task automatic checkOp(input decOpT exp);
		checkVal("op.regN", op.regN, exp.regN);
		checkVal("op.regM", op.regM, exp.regM);
		checkVal("op.regO", op.regO, exp.regO);
		checkVal("op.imm", op.imm, exp.imm);
		checkVal("op.uCmd", op.uCmd, exp.uCmd);
		checkVal("op.uIxt", op.uIxt, exp.uIxt);
	endtask

	// one strobe, result expected on the next edge
	task automatic decodeOne(input logic [15:0] w, input logic [2:0] mode);
		curWord   = w;
		istrWord  = w;
		srMod     = mode;
		istrValid = 1'b1;
		@(posedge clock);
		#5;
		istrValid = 1'b0;
		checkVal("opValid", opValid, 1'b1);
		checkOp(expectOp(w, mode));
	endtask

	task automatic testResetAndPipe();
		logic [15:0] words [3];
		words = '{16'h0123, 16'h1F80, 16'h2F7F};
		checkVal("opValid", opValid, 1'b0);
		checkOp(invalidOp());
		@(posedge clock);
		#5;
		checkVal("opValid", opValid, 1'b0); // no strobe yet
		checkOp(invalidOp());
		decodeOne(16'h1085, 3'b000);
		@(posedge clock);
		#5;
		checkVal("opValid", opValid, 1'b0);
		checkOp(expectOp(16'h1085, 3'b000)); // last op held
		for (int i = 0; i < 3; i++)
			decodeOne(words[i], 3'b000); // back to back
		@(posedge clock);
		#5;
		checkVal("opValid", opValid, 1'b0);
	endtask

	task automatic testRegReg();
		logic [3:0] fields [3];
		fields = '{4'h0, 4'h5, 4'hF};
		for (int s = 0; s < 6; s++)
			for (int n = 0; n < 3; n++)
				for (int m = 0; m < 3; m++)
					decodeOne({4'h0, 4'(s), fields[n], fields[m]}, 3'b000);
		for (int s = 6; s < 16; s++)
			decodeOne({4'h0, 4'(s), 8'h3C}, 3'b000); // reserved sub-opcodes
		for (int mj = 8; mj < 16; mj++)
			decodeOne({4'(mj), 12'($random(seed))}, 3'b000);
	endtask

	task automatic testImmediates();
		logic [3:0]  majors [5];
		logic [31:0] r;
		logic [15:0] w;
		majors = '{4'h1, 4'h2, 4'h3, 4'h5, 4'h6};
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			w = {majors[i % 5], r[11:0]};
			if (i % 2 == 0)
				w[7] = 1'b1; // negative byte
			decodeOne(w, r[18:16]);
		end
	endtask

	task automatic testBtyPack();
		logic [31:0] r;
		for (int s = 0; s < 16; s++) begin
			r = $random(seed);
			decodeOne({4'h4, 4'(s), r[7:0]}, 3'b000);
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			decodeOne({4'h5, r[11:0]}, 3'b001);
		end
		decodeOne(16'h7ABC, 3'b000);
	endtask

	task automatic testPrivilege();
		for (int md = 0; md < 2; md++) begin
			for (int idx = 0; idx < 16; idx++) begin
				decodeOne({8'h04, 4'(idx), 4'h3}, 3'(md)); // write Cn
				decodeOne({8'h05, 4'h2, 4'(idx)}, 3'(md)); // read Cm
			end
		end
	endtask

	initial begin
		seed       = 20;
		errCount   = 0;
		checkCount = 0;
		curWord    = '0;
		rstN       = 1'b0;
		istrWord   = '0;
		istrValid  = 1'b0;
		srMod      = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#5;
		rstN = 1'b1;
		testResetAndPipe();
		testRegReg();
		testImmediates();
		testBtyPack();
		testPrivilege();
		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hw/rvcDecPkg.sv
hw/rvcOpTable.sv
hw/rvcOperandSel.sv
hw/rvcPrivGate.sv
hw/rvcDecodeStage.sv
sim/rvcDecodeTb.sv
